// File: filelist.f
design/soc_pkg.sv
design/soc_bus_demux.sv
design/soc_l2_mem.sv
design/soc_ctrl_regs.sv
design/soc_uart_apb.sv
design/soc_top.sv
sim/soc_uart_model.sv
sim/soc_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the SoC testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module soc_tb -f filelist.f

output=$(./obj_dir/Vsoc_tb 2>&1 || true)
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -qx 'No errors'; then
  exit 0
fi
exit 1

// File: sim/soc_tb.sv
// Testbench for the SoC memory system
//   Clock, reset and the stimulus table
//   Reference model for L2, control and UART registers
//   Response and register checks

module soc_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned L2Words    = 256;
  localparam int unsigned L2IdxW     = $clog2(L2Words);
  localparam int unsigned UartDepth  = 4;
  localparam int unsigned Timeout    = 20;
  localparam int unsigned NumEntries = 28;
  localparam logic [31:0] Seed       = 32'h2f838b1e;

  typedef struct {
    logic               we;
    soc_pkg::bus_addr_t addr;
    soc_pkg::bus_strb_t be;
    soc_pkg::bus_data_t wdata;
    soc_pkg::bus_data_t rdata;
    logic               err;
  } entry_t;

  logic               clk;
  logic               reset;
  logic               req;
  logic               we;
  soc_pkg::bus_addr_t addr;
  soc_pkg::bus_strb_t be;
  soc_pkg::bus_data_t wdata;
  logic               gnt;
  logic               rvalid;
  soc_pkg::bus_data_t rdata;
  logic               err;
  soc_pkg::bus_data_t exit_val;
  soc_pkg::bus_data_t hw_cnt_en;
  logic               psel;
  logic               penable;
  logic               pwrite;
  soc_pkg::bus_addr_t paddr;
  soc_pkg::bus_data_t pwdata;
  soc_pkg::bus_data_t prdata;
  logic               pready;
  logic               pslverr;
  soc_pkg::bus_data_t exp_exit  [NumEntries];
  soc_pkg::bus_data_t exp_hwcnt [NumEntries];

  // we, addr, be, wdata, rdata (filled by the reference model), err
  entry_t stim [NumEntries] = '{
    '{1'b1, 32'h8000_0000, 4'hF, 32'h1122_3344, 32'h0, 1'b0},
    '{1'b1, 32'h8000_0004, 4'hF, 32'hAABB_CCDD, 32'h0, 1'b0},
    '{1'b1, 32'h8000_0000, 4'h5, 32'h5566_7788, 32'h0, 1'b0},
    '{1'b1, 32'h8000_0004, 4'h8, 32'hFF00_0000, 32'h0, 1'b0},
    '{1'b0, 32'h8000_0000, 4'hF, 32'h0,         32'h0, 1'b0},
    '{1'b0, 32'h8000_0004, 4'hF, 32'h0,         32'h0, 1'b0},
    // One full memory above the base lands on word 0
    '{1'b1, 32'h8000_0400, 4'h2, 32'h0000_9900, 32'h0, 1'b0},
    '{1'b0, 32'h8000_0000, 4'hF, 32'h0,         32'h0, 1'b0},
    '{1'b0, 32'h8000_0400, 4'hF, 32'h0,         32'h0, 1'b0},
    '{1'b1, 32'hD000_0000, 4'h1, 32'h0000_0001, 32'h0, 1'b0},
    '{1'b1, 32'hD000_0004, 4'h3, 32'h0000_ABCD, 32'h0, 1'b0},
    '{1'b1, 32'hD000_0004, 4'hC, 32'h1234_0000, 32'h0, 1'b0},
    '{1'b0, 32'hD000_0000, 4'hF, 32'h0,         32'h0, 1'b0},
    '{1'b0, 32'hD000_0004, 4'hF, 32'h0,         32'h0, 1'b0},
    '{1'b0, 32'hD000_0008, 4'hF, 32'h0,         32'h0, 1'b0},
    '{1'b0, 32'hD000_000C, 4'hF, 32'h0,         32'h0, 1'b0},
    '{1'b1, 32'hD000_0008, 4'hF, 32'hDEAD_BEEF, 32'h0, 1'b0},
    '{1'b0, 32'hD000_0008, 4'hF, 32'h0,         32'h0, 1'b0},
    '{1'b1, 32'hC000_0000, 4'hF, 32'hCAFE_0001, 32'h0, 1'b0},
    '{1'b1, 32'hC000_000C, 4'hF, 32'hCAFE_000C, 32'h0, 1'b0},
    '{1'b0, 32'hC000_0000, 4'hF, 32'h0,         32'h0, 1'b0},
    '{1'b0, 32'hC000_000C, 4'hF, 32'h0,         32'h0, 1'b0},
    '{1'b1, 32'hC000_0020, 4'hF, 32'h0BAD_0020, 32'h0, 1'b1},
    '{1'b0, 32'hC000_0020, 4'hF, 32'h0,         32'h0, 1'b1},
    '{1'b0, 32'h0000_1000, 4'hF, 32'h0,         32'h0, 1'b1},
    '{1'b1, 32'h0000_1000, 4'hF, 32'h1234_5678, 32'h0, 1'b1},
    '{1'b0, 32'h8000_0004, 4'hF, 32'h0,         32'h0, 1'b0},
    '{1'b0, 32'hD000_0010, 4'hF, 32'h0,         32'h0, 1'b0}
  };

  soc_top #(
    .L2NumWords (L2Words)
  ) soc_top_inst (
    .clk_i          (clk      ),
    .reset_i        (reset    ),
    .req_i          (req      ),
    .we_i           (we       ),
    .addr_i         (addr     ),
    .be_i           (be       ),
    .wdata_i        (wdata    ),
    .gnt_o          (gnt      ),
    .rvalid_o       (rvalid   ),
    .rdata_o        (rdata    ),
    .err_o          (err      ),
    .exit_o         (exit_val ),
    .hw_cnt_en_o    (hw_cnt_en),
    .uart_psel_o    (psel     ),
    .uart_penable_o (penable  ),
    .uart_pwrite_o  (pwrite   ),
    .uart_paddr_o   (paddr    ),
    .uart_pwdata_o  (pwdata   ),
    .uart_prdata_i  (prdata   ),
    .uart_pready_i  (pready   ),
    .uart_pslverr_i (pslverr  )
  );

  soc_uart_model #(
    .Depth (UartDepth),
    .Seed  (Seed     )
  ) soc_uart_model_inst (
    .clk_i     (clk    ),
    .reset_i   (reset  ),
    .psel_i    (psel   ),
    .penable_i (penable),
    .pwrite_i  (pwrite ),
    .paddr_i   (paddr  ),
    .pwdata_i  (pwdata ),
    .prdata_o  (prdata ),
    .pready_o  (pready ),
    .pslverr_o (pslverr)
  );

  always #4 clk = ~clk;

  //////////////////////////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////////////////////////

  function automatic soc_pkg::bus_data_t merge_bytes(input soc_pkg::bus_data_t old_w,
                                                     input soc_pkg::bus_data_t new_w,
                                                     input soc_pkg::bus_strb_t strb);
    soc_pkg::bus_data_t res;
    res = old_w;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) res[8*b +: 8] = new_w[8*b +: 8];
    end
    return res;
  endfunction

  task automatic compute_expected();
    soc_pkg::bus_data_t l2_ref   [L2Words];
    soc_pkg::bus_data_t uart_ref [UartDepth];
    soc_pkg::bus_data_t exit_ref;
    soc_pkg::bus_data_t hwcnt_ref;
    soc_pkg::bus_addr_t a;
    logic [L2IdxW-1:0]  w;
    exit_ref  = '0;
    hwcnt_ref = '0;
    for (int i = 0; i < NumEntries; i++) begin
      a = stim[i].addr;
      if (a[31:30] == 2'b10) begin
        // Word index wraps at the memory size
        w = L2IdxW'(((a - 32'h8000_0000) >> 2) % L2Words);
        if (stim[i].we) l2_ref[w] = merge_bytes(l2_ref[w], stim[i].wdata, stim[i].be);
        else stim[i].rdata = l2_ref[w];
      end else if (a[31:12] == 20'hC0000 && a[11:4] == 8'h00) begin
        if (stim[i].we) uart_ref[a[3:2]] = stim[i].wdata;
        else stim[i].rdata = uart_ref[a[3:2]];
      end else if (a[31:12] == 20'hD0000) begin
        if (stim[i].we && a[11:0] == 12'h000) begin
          exit_ref = merge_bytes(exit_ref, stim[i].wdata, stim[i].be);
        end else if (stim[i].we && a[11:0] == 12'h004) begin
          hwcnt_ref = merge_bytes(hwcnt_ref, stim[i].wdata, stim[i].be);
        end else if (!stim[i].we) begin
          case (a[11:0])
            12'h000: stim[i].rdata = exit_ref;
            12'h004: stim[i].rdata = hwcnt_ref;
            12'h008: stim[i].rdata = 32'h8000_0000;
            12'h00C: stim[i].rdata = 32'hC000_0000;
            default: stim[i].rdata = 32'h0;
          endcase
        end
      end
      exp_exit[i]  = exit_ref;
      exp_hwcnt[i] = hwcnt_ref;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////////////////////////

  task automatic stop_run();
    $display("Errors found");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check_data(input soc_pkg::bus_data_t got, input soc_pkg::bus_data_t exp,
                            input soc_pkg::bus_addr_t a);
    if (got !== exp) begin
      $display("[FAIL] %0t: read of 0x%08h gave 0x%08h, expected 0x%08h", $time, a, got, exp);
      stop_run();
    end
  endtask

  task automatic check_err(input logic got, input logic exp, input soc_pkg::bus_addr_t a);
    if (got !== exp) begin
      $display("[FAIL] %0t: err_o for 0x%08h is %b, expected %b", $time, a, got, exp);
      stop_run();
    end
  endtask

  task automatic check_reg(input soc_pkg::bus_data_t got, input soc_pkg::bus_data_t exp,
                           input string what);
    if (got !== exp) begin
      $display("[FAIL] %0t: %s is 0x%08h, expected 0x%08h", $time, what, got, exp);
      stop_run();
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("[FAIL] %0t: %s is %b, expected %b", $time, what, got, exp);
      stop_run();
    end
  endtask

  task automatic check_response(input int idx);
    check_flag(rvalid, 1'b1, "rvalid_o one cycle after grant");
    check_err(err, stim[idx].err, stim[idx].addr);
    if (!stim[idx].we && !stim[idx].err) begin
      check_data(rdata, stim[idx].rdata, stim[idx].addr);
    end
    check_reg(exit_val, exp_exit[idx], "exit_o");
    check_reg(hw_cnt_en, exp_hwcnt[idx], "hw_cnt_en_o");
  endtask

  //////////////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////////////

  initial begin
    int unsigned waited;
    int          pend;
    clk   = 1'b0;
    reset = 1'b1;
    req   = 1'b0;
    we    = 1'b0;
    addr  = '0;
    be    = '0;
    wdata = '0;
    compute_expected();
    repeat (5) @(negedge clk);
    reset = 1'b0;

    // Idle port after reset
    repeat (3) begin
      @(negedge clk);
      #1;
      check_flag(gnt, 1'b0, "gnt_o while idle");
      check_flag(rvalid, 1'b0, "rvalid_o while idle");
      check_flag(err, 1'b0, "err_o while idle");
      check_flag(psel, 1'b0, "uart_psel_o while idle");
      check_flag(penable, 1'b0, "uart_penable_o while idle");
    end
    check_reg(exit_val, '0, "exit_o after reset");
    check_reg(hw_cnt_en, '0, "hw_cnt_en_o after reset");

    // Next request goes out while the previous one responds
    pend = -1;
    for (int i = 0; i < NumEntries; i++) begin
      @(negedge clk);
      req   = 1'b1;
      we    = stim[i].we;
      addr  = stim[i].addr;
      be    = stim[i].be;
      wdata = stim[i].wdata;
      #1;
      if (pend >= 0) check_response(pend);
      // Only UART requests may wait for a grant
      if (stim[i].addr[31:12] != 20'hC0000) begin
        check_flag(gnt, 1'b1, "gnt_o in the cycle of the request");
      end
      waited = 0;
      while (gnt !== 1'b1) begin
        if (waited == Timeout) begin
          $display("Timeout: gnt_o never arrived for request to 0x%08h", stim[i].addr);
          stop_run();
        end
        @(negedge clk);
        #1;
        check_flag(rvalid, 1'b0, "rvalid_o while waiting for grant");
        waited++;
      end
      pend = i;
    end

    @(negedge clk);
    req = 1'b0;
    #1;
    check_response(pend);
    @(negedge clk);
    #1;
    check_flag(rvalid, 1'b0, "rvalid_o after the last response");

    $display("No errors");
    $finish;
  end

endmodule : soc_tb

// File: sim/soc_uart_model.sv
// APB UART register model
//   Word registers at offsets from zero, slave error above them
//   Random wait states from an xorshift generator

module soc_uart_model #(
  parameter int unsigned Depth = 4,
  parameter logic [31:0] Seed  = 32'h0000_0001
) (
  input  logic                 clk_i,
  input  logic                 reset_i,
  input  logic                 psel_i,
  input  logic                 penable_i,
  input  logic                 pwrite_i,
  input  soc_pkg::bus_addr_t   paddr_i,
  input  soc_pkg::bus_data_t   pwdata_i,
  output soc_pkg::bus_data_t   prdata_o,
  output logic                 pready_o,
  output logic                 pslverr_o
);
  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned IdxWidth = $clog2(Depth);

  soc_pkg::bus_data_t  regs [Depth];
  logic [31:0]         rng_q;
  logic [31:0]         rng_next;
  logic [1:0]          wait_q;
  logic                in_range;
  logic [IdxWidth-1:0] idx;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  assign rng_next  = xorshift32(rng_q);
  assign in_range  = paddr_i < Depth * 4;
  assign idx       = paddr_i[IdxWidth+1:2];
  assign pready_o  = psel_i && penable_i && (wait_q == 2'd0);
  assign pslverr_o = pready_o && !in_range;
  assign prdata_o  = in_range ? regs[idx] : '0;

  always @(posedge clk_i) begin
    if (reset_i) begin
      rng_q  <= Seed;
      wait_q <= 2'd0;
    end else if (psel_i && !penable_i) begin
      // Setup phase draws the wait count
      rng_q  <= rng_next;
      wait_q <= rng_next[1:0];
    end else if (psel_i && penable_i && wait_q != 2'd0) begin
      wait_q <= wait_q - 2'd1;
    end
  end

  always @(posedge clk_i) begin
    if (pready_o && pwrite_i && in_range) begin
      regs[idx] <= pwdata_i;
    end
  end

endmodule : soc_uart_model

// File: design/soc_top.sv
// SoC memory system top level
//   Request demux, L2 memory, control registers, UART APB master

module soc_top #(
  parameter int unsigned L2NumWords = 1024
) (
  input  logic                 clk_i,
  input  logic                 reset_i,
  // Outside request port
  input  logic                 req_i,
  input  logic                 we_i,
  input  soc_pkg::bus_addr_t   addr_i,
  input  soc_pkg::bus_strb_t   be_i,
  input  soc_pkg::bus_data_t   wdata_i,
  output logic                 gnt_o,
  output logic                 rvalid_o,
  output soc_pkg::bus_data_t   rdata_o,
  output logic                 err_o,
  // Control outputs
  output soc_pkg::bus_data_t   exit_o,
  output soc_pkg::bus_data_t   hw_cnt_en_o,
  // UART APB port
  output logic                 uart_psel_o,
  output logic                 uart_penable_o,
  output logic                 uart_pwrite_o,
  output soc_pkg::bus_addr_t   uart_paddr_o,
  output soc_pkg::bus_data_t   uart_pwdata_o,
  input  soc_pkg::bus_data_t   uart_prdata_i,
  input  logic                 uart_pready_i,
  input  logic                 uart_pslverr_i
);

  logic               l2_req;
  logic               ctrl_req;
  logic               uart_req;
  logic               bus_we;
  soc_pkg::bus_addr_t bus_addr;
  soc_pkg::bus_strb_t bus_be;
  soc_pkg::bus_data_t bus_wdata;
  soc_pkg::bus_data_t l2_rdata;
  soc_pkg::bus_data_t ctrl_rdata;
  logic               uart_gnt;
  soc_pkg::bus_data_t uart_rdata;
  logic               uart_err;

  soc_bus_demux soc_bus_demux_inst (
    .clk_i        (clk_i     ),
    .reset_i      (reset_i   ),
    .req_i        (req_i     ),
    .we_i         (we_i      ),
    .addr_i       (addr_i    ),
    .be_i         (be_i      ),
    .wdata_i      (wdata_i   ),
    .gnt_o        (gnt_o     ),
    .rvalid_o     (rvalid_o  ),
    .rdata_o      (rdata_o   ),
    .err_o        (err_o     ),
    .l2_req_o     (l2_req    ),
    .ctrl_req_o   (ctrl_req  ),
    .uart_req_o   (uart_req  ),
    .we_o         (bus_we    ),
    .addr_o       (bus_addr  ),
    .be_o         (bus_be    ),
    .wdata_o      (bus_wdata ),
    .l2_rdata_i   (l2_rdata  ),
    .ctrl_rdata_i (ctrl_rdata),
    .uart_gnt_i   (uart_gnt  ),
    .uart_rdata_i (uart_rdata),
    .uart_err_i   (uart_err  )
  );

  //////////////////////////////////////////////////////////////////////
  // Targets
  //////////////////////////////////////////////////////////////////////

  soc_l2_mem #(
    .L2NumWords (L2NumWords)
  ) soc_l2_mem_inst (
    .clk_i   (clk_i    ),
    .req_i   (l2_req   ),
    .we_i    (bus_we   ),
    .addr_i  (bus_addr ),
    .be_i    (bus_be   ),
    .wdata_i (bus_wdata),
    .rdata_o (l2_rdata )
  );

  soc_ctrl_regs soc_ctrl_regs_inst (
    .clk_i       (clk_i      ),
    .reset_i     (reset_i    ),
    .req_i       (ctrl_req   ),
    .we_i        (bus_we     ),
    .addr_i      (bus_addr   ),
    .be_i        (bus_be     ),
    .wdata_i     (bus_wdata  ),
    .rdata_o     (ctrl_rdata ),
    .exit_o      (exit_o     ),
    .hw_cnt_en_o (hw_cnt_en_o)
  );

  soc_uart_apb soc_uart_apb_inst (
    .clk_i     (clk_i         ),
    .reset_i   (reset_i       ),
    .req_i     (uart_req      ),
    .we_i      (bus_we        ),
    .addr_i    (bus_addr      ),
    .wdata_i   (bus_wdata     ),
    .gnt_o     (uart_gnt      ),
    .rdata_o   (uart_rdata    ),
    .err_o     (uart_err      ),
    .psel_o    (uart_psel_o   ),
    .penable_o (uart_penable_o),
    .pwrite_o  (uart_pwrite_o ),
    .paddr_o   (uart_paddr_o  ),
    .pwdata_o  (uart_pwdata_o ),
    .prdata_i  (uart_prdata_i ),
    .pready_i  (uart_pready_i ),
    .pslverr_i (uart_pslverr_i)
  );

endmodule : soc_top

// File: design/soc_uart_apb.sv
// APB master for the external UART
//   Idle, setup and access FSM
//   Address offset within the UART region on paddr
//   Registered read data and slave error for the response cycle

module soc_uart_apb (
  input  logic                 clk_i,
  input  logic                 reset_i,
  input  logic                 req_i,
  input  logic                 we_i,
  input  soc_pkg::bus_addr_t   addr_i,
  input  soc_pkg::bus_data_t   wdata_i,
  output logic                 gnt_o,
  output soc_pkg::bus_data_t   rdata_o,
  output logic                 err_o,
  // APB master
  output logic                 psel_o,
  output logic                 penable_o,
  output logic                 pwrite_o,
  output soc_pkg::bus_addr_t   paddr_o,
  output soc_pkg::bus_data_t   pwdata_o,
  input  soc_pkg::bus_data_t   prdata_i,
  input  logic                 pready_i,
  input  logic                 pslverr_i
);

  typedef enum logic [1:0] {
    IDLE,
    SETUP,
    ACCESS
  } apb_state_e;

  apb_state_e state_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= IDLE;
    end else begin
      case (state_q)
        IDLE:    if (req_i) state_q <= SETUP;
        SETUP:   state_q <= ACCESS;
        ACCESS:  if (pready_i) state_q <= IDLE;
        default: state_q <= IDLE;
      endcase
    end
  end

  // Capture the request for the whole transfer
  always_ff @(posedge clk_i) begin
    if (state_q == IDLE && req_i) begin
      pwrite_o <= we_i;
      paddr_o  <= addr_i - soc_pkg::UART_BASE;
      pwdata_o <= wdata_i;
    end
  end

  assign psel_o    = (state_q != IDLE);
  assign penable_o = (state_q == ACCESS);
  assign gnt_o     = (state_q == ACCESS) && pready_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      err_o <= 1'b0;
    end else if (gnt_o) begin
      err_o <= pslverr_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (gnt_o) begin
      rdata_o <= prdata_i;
    end
  end

endmodule : soc_uart_apb

// File: design/soc_ctrl_regs.sv
// Control register block in the CTRL region
//   exit and hw_cnt_en registers with byte enables
//   Read-only DRAM base and end registers

module soc_ctrl_regs (
  input  logic                 clk_i,
  input  logic                 reset_i,
  input  logic                 req_i,
  input  logic                 we_i,
  input  soc_pkg::bus_addr_t   addr_i,
  input  soc_pkg::bus_strb_t   be_i,
  input  soc_pkg::bus_data_t   wdata_i,
  output soc_pkg::bus_data_t   rdata_o,
  output soc_pkg::bus_data_t   exit_o,
  output soc_pkg::bus_data_t   hw_cnt_en_o
);

  logic [11:0]        ofs;
  soc_pkg::bus_data_t exit_q;
  soc_pkg::bus_data_t hw_cnt_en_q;
  soc_pkg::bus_data_t rdata_d;

  assign ofs = addr_i[11:0];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      exit_q      <= '0;
      hw_cnt_en_q <= '0;
    end else if (req_i && we_i) begin
      for (int b = 0; b < 4; b++) begin
        if (be_i[b] && ofs == soc_pkg::CTRL_EXIT_OFS) begin
          exit_q[8*b +: 8] <= wdata_i[8*b +: 8];
        end
        if (be_i[b] && ofs == soc_pkg::CTRL_HWCNT_OFS) begin
          hw_cnt_en_q[8*b +: 8] <= wdata_i[8*b +: 8];
        end
      end
    end
  end

  // Read mux, unknown offsets give zero
  always_comb begin
    case (ofs)
      soc_pkg::CTRL_EXIT_OFS:      rdata_d = exit_q;
      soc_pkg::CTRL_HWCNT_OFS:     rdata_d = hw_cnt_en_q;
      soc_pkg::CTRL_DRAM_BASE_OFS: rdata_d = soc_pkg::DRAM_BASE;
      soc_pkg::CTRL_DRAM_END_OFS:  rdata_d = soc_pkg::DRAM_BASE + soc_pkg::DRAM_LENGTH;
      default:                     rdata_d = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (req_i && !we_i) begin
      rdata_o <= rdata_d;
    end
  end

  assign exit_o      = exit_q;
  assign hw_cnt_en_o = hw_cnt_en_q;

endmodule : soc_ctrl_regs

// File: design/soc_l2_mem.sv
// L2 word memory
//   Byte-enable writes
//   Registered read data, one cycle after the strobe

module soc_l2_mem #(
  parameter int unsigned L2NumWords = 1024
) (
  input  logic                 clk_i,
  input  logic                 req_i,
  input  logic                 we_i,
  input  soc_pkg::bus_addr_t   addr_i,
  input  soc_pkg::bus_strb_t   be_i,
  input  soc_pkg::bus_data_t   wdata_i,
  output soc_pkg::bus_data_t   rdata_o
);

  localparam int unsigned IdxWidth = $clog2(L2NumWords);

  soc_pkg::bus_data_t  mem [L2NumWords];
  logic [IdxWidth-1:0] idx;

  // Word index above the byte offset, upper bits alias
  assign idx = addr_i[IdxWidth+1:2];

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (we_i) begin
        for (int b = 0; b < 4; b++) begin
          if (be_i[b]) begin
            mem[idx][8*b +: 8] <= wdata_i[8*b +: 8];
          end
        end
      end else begin
        rdata_o <= mem[idx];
      end
    end
  end

endmodule : soc_l2_mem

// File: design/soc_bus_demux.sv
// Request demux on the outside port
//   Address decode over the L2, UART and CTRL regions
//   Target strobes and grant generation
//   Registered target used to merge the responses

module soc_bus_demux (
  input  logic                 clk_i,
  input  logic                 reset_i,
  // Outside request port
  input  logic                 req_i,
  input  logic                 we_i,
  input  soc_pkg::bus_addr_t   addr_i,
  input  soc_pkg::bus_strb_t   be_i,
  input  soc_pkg::bus_data_t   wdata_i,
  output logic                 gnt_o,
  output logic                 rvalid_o,
  output soc_pkg::bus_data_t   rdata_o,
  output logic                 err_o,
  // Target strobes and shared request fields
  output logic                 l2_req_o,
  output logic                 ctrl_req_o,
  output logic                 uart_req_o,
  output logic                 we_o,
  output soc_pkg::bus_addr_t   addr_o,
  output soc_pkg::bus_strb_t   be_o,
  output soc_pkg::bus_data_t   wdata_o,
  // Target responses
  input  soc_pkg::bus_data_t   l2_rdata_i,
  input  soc_pkg::bus_data_t   ctrl_rdata_i,
  input  logic                 uart_gnt_i,
  input  soc_pkg::bus_data_t   uart_rdata_i,
  input  logic                 uart_err_i
);

  soc_pkg::soc_target_e target;
  soc_pkg::soc_target_e target_q;
  logic                 valid_q;

  //////////////////////////////////////////////////////////////////////
  // Decode
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    target = soc_pkg::TGT_NONE;
    if (addr_i >= soc_pkg::DRAM_BASE &&
        addr_i < soc_pkg::DRAM_BASE + soc_pkg::DRAM_LENGTH) begin
      target = soc_pkg::TGT_L2;
    end else if (addr_i >= soc_pkg::UART_BASE &&
                 addr_i < soc_pkg::UART_BASE + soc_pkg::UART_LENGTH) begin
      target = soc_pkg::TGT_UART;
    end else if (addr_i >= soc_pkg::CTRL_BASE &&
                 addr_i < soc_pkg::CTRL_BASE + soc_pkg::CTRL_LENGTH) begin
      target = soc_pkg::TGT_CTRL;
    end
  end

  assign l2_req_o   = req_i && (target == soc_pkg::TGT_L2);
  assign ctrl_req_o = req_i && (target == soc_pkg::TGT_CTRL);
  assign uart_req_o = req_i && (target == soc_pkg::TGT_UART);
  assign we_o       = we_i;
  assign addr_o     = addr_i;
  assign be_o       = be_i;
  assign wdata_o    = wdata_i;

  // Only the UART can stall, everything else is granted at once
  assign gnt_o = req_i && ((target == soc_pkg::TGT_UART) ? uart_gnt_i : 1'b1);

  //////////////////////////////////////////////////////////////////////
  // Response
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_q  <= 1'b0;
      target_q <= soc_pkg::TGT_NONE;
    end else begin
      valid_q <= gnt_o;
      if (gnt_o) begin
        target_q <= target;
      end
    end
  end

  assign rvalid_o = valid_q;

  always_comb begin
    case (target_q)
      soc_pkg::TGT_L2:   rdata_o = l2_rdata_i;
      soc_pkg::TGT_CTRL: rdata_o = ctrl_rdata_i;
      soc_pkg::TGT_UART: rdata_o = uart_rdata_i;
      default:           rdata_o = '0;
    endcase
  end

  assign err_o = valid_q && ((target_q == soc_pkg::TGT_NONE) ||
                             (target_q == soc_pkg::TGT_UART && uart_err_i));

endmodule : soc_bus_demux

// File: design/soc_pkg.sv
// Shared definitions for the SoC memory system
//   Bus address, data and byte-enable types
//   Target enumeration used by the request demux
//   Memory map and control register offsets

package soc_pkg;

  typedef logic [31:0] bus_addr_t;
  typedef logic [31:0] bus_data_t;
  typedef logic [3:0]  bus_strb_t;

  // Target selected for a granted request
  typedef enum logic [1:0] {
    TGT_L2   = 2'd0,
    TGT_UART = 2'd1,
    TGT_CTRL = 2'd2,
    TGT_NONE = 2'd3
  } soc_target_e;

  //////////////////////////////////////////////////////////////////////
  // Memory map
  //////////////////////////////////////////////////////////////////////

  localparam bus_addr_t DRAM_BASE   = 32'h8000_0000;
  localparam bus_addr_t DRAM_LENGTH = 32'h4000_0000;
  localparam bus_addr_t UART_BASE   = 32'hC000_0000;
  localparam bus_addr_t UART_LENGTH = 32'h0000_1000;
  localparam bus_addr_t CTRL_BASE   = 32'hD000_0000;
  localparam bus_addr_t CTRL_LENGTH = 32'h0000_1000;

  // Control register offsets
  localparam logic [11:0] CTRL_EXIT_OFS      = 12'h000;
  localparam logic [11:0] CTRL_HWCNT_OFS     = 12'h004;
  localparam logic [11:0] CTRL_DRAM_BASE_OFS = 12'h008;
  localparam logic [11:0] CTRL_DRAM_END_OFS  = 12'h00C;

endpackage : soc_pkg
